// ==== compile.f ====
logic/cache_pkg.sv
logic/byte_lanes.sv
logic/line_store.sv
logic/line_transfer.sv
logic/access_stage.sv
logic/cache_top.sv
testbench/cache_asserts.sv
testbench/tb_cache.sv

// ==== logic/access_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module access_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] address,
    input  logic        load,
    input  logic [2:0]  load_type,
    input  logic        store,
    input  logic [1:0]  store_type,
    input  logic [31:0] store_data,
    input  logic        fault,
    output logic        busy,
    output logic        done,

    output logic                                            rd_en,
    output logic [cache_pkg::LANES_W-1:0]                   rd_lane,
    output logic [cache_pkg::OFFSET_W-1:0]                  rd_offset,
    input  logic [cache_pkg::WAYS-1:0][cache_pkg::TAG_W-1:0] rd_tag,
    input  logic [cache_pkg::WAYS-1:0][31:0]                rd_data,
    input  logic [cache_pkg::WAYS-1:0]                      rd_valid,
    input  logic [cache_pkg::WAYS-1:0]                      rd_dirty,

    output logic                         wr_en,
    output logic [cache_pkg::WAYS_W-1:0] wr_way,
    output logic [31:0]                  wr_data,
    output logic                         set_dirty,
    input  logic [31:0]                  merged_word,

    output logic [31:0] hit_word,
    output logic [1:0]  byte_offset,
    output logic [2:0]  held_load_type,
    output logic [1:0]  held_store_type,
    output logic [31:0] held_store_data,
    output logic        held_load,
    output logic        held_store,

    input  logic [cache_pkg::WAYS_W-1:0] victim_way,
    output logic                         miss_start,
    output logic [31:0]                  miss_line_address,
    output logic [cache_pkg::TAG_W-1:0]  victim_tag,
    output logic                         victim_needs_writeback,
    input  logic                         fill_done
);

    cache_pkg::cache_addr_t       req_addr;
    cache_pkg::cache_addr_t       held_addr;
    cache_pkg::cache_addr_t       line_addr;
    logic                         accept;
    logic                         active;
    logic                         waiting;
    logic                         replay;
    logic                         hit;
    logic                         miss;
    logic [cache_pkg::WAYS_W-1:0] hit_way;

    assign req_addr = address;
    assign accept   = (load || store) && !busy;

    // Lookup is issued straight from the request, or from the held one on replay
    assign rd_en     = accept || replay;
    assign rd_lane   = replay ? held_addr.fields.lane : req_addr.fields.lane;
    assign rd_offset = replay ? held_addr.fields.offset : req_addr.fields.offset;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (rd_valid[w] && rd_tag[w] == held_addr.fields.tag) begin
                hit     = 1'b1;
                hit_way = cache_pkg::WAYS_W'(w);
            end
        end
    end

    assign hit_word = rd_data[hit_way];
    // Faulted accesses finish at once and never reach memory
    assign miss = active && !fault && !hit;
    assign done = active && (fault || hit);
    assign busy = waiting || replay || miss;

    assign wr_en     = active && hit && held_store && !fault;
    assign set_dirty = wr_en;
    assign wr_way    = hit_way;
    assign wr_data   = merged_word;

    always_comb begin
        line_addr                    = held_addr;
        line_addr.fields.offset      = '0;
        line_addr.fields.byte_offset = '0;
    end

    assign miss_start             = miss;
    assign miss_line_address      = line_addr.raw;
    assign victim_tag             = rd_tag[victim_way];
    assign victim_needs_writeback = rd_valid[victim_way] && rd_dirty[victim_way];
    assign byte_offset            = held_addr.fields.byte_offset;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active     <= 1'b0;
            waiting    <= 1'b0;
            replay     <= 1'b0;
            held_load  <= 1'b0;
            held_store <= 1'b0;
        end else begin
            active <= accept || replay;
            replay <= fill_done;
            if (miss) begin
                waiting <= 1'b1;
            end else if (fill_done) begin
                waiting <= 1'b0;
            end
            if (accept) begin
                held_load  <= load;
                held_store <= store;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_addr       <= req_addr;
            held_load_type  <= load_type;
            held_store_type <= store_type;
            held_store_data <= store_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/byte_lanes.sv ====
`default_nettype none
`timescale 1ns/1ps

module byte_lanes (
    input  logic [1:0]  byte_offset,
    input  logic [2:0]  held_load_type,
    input  logic [1:0]  held_store_type,
    input  logic [31:0] hit_word,
    input  logic [31:0] held_store_data,
    input  logic        held_load,
    input  logic        held_store,
    output logic [31:0] load_data,
    output logic [31:0] merged_word,
    output logic        fault,
    output logic        load_misaligned,
    output logic        load_unknown_type,
    output logic        store_misaligned,
    output logic        store_unknown_type
);

    logic [31:0] shifted;
    logic [31:0] lane_data;
    logic [3:0]  lane_mask;
    logic        load_half;
    logic        load_word;

    // Addressed byte moved down to bit 0
    assign shifted = hit_word >> {byte_offset, 3'b000};

    always_comb begin
        case (held_load_type)
            cache_pkg::LOAD_BYTE:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            cache_pkg::LOAD_BYTE_U: load_data = {24'd0, shifted[7:0]};
            cache_pkg::LOAD_HALF:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            cache_pkg::LOAD_HALF_U: load_data = {16'd0, shifted[15:0]};
            cache_pkg::LOAD_WORD:   load_data = hit_word;
            default:                load_data = '0;
        endcase
    end

    // Store data replicated over all lanes, mask picks the written bytes
    always_comb begin
        case (held_store_type)
            cache_pkg::STORE_BYTE: begin
                lane_data = {4{held_store_data[7:0]}};
                lane_mask = 4'b0001 << byte_offset;
            end
            cache_pkg::STORE_HALF: begin
                lane_data = {2{held_store_data[15:0]}};
                lane_mask = 4'b0011 << byte_offset;
            end
            cache_pkg::STORE_WORD: begin
                lane_data = held_store_data;
                lane_mask = 4'b1111;
            end
            default: begin
                lane_data = held_store_data;
                lane_mask = 4'b0000;
            end
        endcase
        for (int b = 0; b < 4; b++) begin
            merged_word[b*8 +: 8] = lane_mask[b] ? lane_data[b*8 +: 8] : hit_word[b*8 +: 8];
        end
    end

    assign load_half = held_load_type == cache_pkg::LOAD_HALF ||
                       held_load_type == cache_pkg::LOAD_HALF_U;
    assign load_word = held_load_type == cache_pkg::LOAD_WORD;

    assign load_unknown_type = held_load && !(load_half || load_word ||
                               held_load_type == cache_pkg::LOAD_BYTE ||
                               held_load_type == cache_pkg::LOAD_BYTE_U);
    assign load_misaligned = held_load && ((load_half && byte_offset[0]) ||
                             (load_word && byte_offset != 2'd0));

    assign store_unknown_type = held_store && held_store_type == 2'd3;
    assign store_misaligned = held_store &&
        ((held_store_type == cache_pkg::STORE_HALF && byte_offset[0]) ||
         (held_store_type == cache_pkg::STORE_WORD && byte_offset != 2'd0));

    assign fault = load_misaligned || load_unknown_type || store_misaligned ||
                   store_unknown_type;

endmodule

`default_nettype wire

// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // Cache geometry
    localparam int WAYS_W     = 1;
    localparam int WAYS       = 2;
    localparam int LANES_W    = 4;
    localparam int OFFSET_W   = 4;
    localparam int LINE_WORDS = 16;
    // Physical tag is what is left above lane, word and byte offset
    localparam int TAG_W      = 32 - LANES_W - OFFSET_W - 2;

    // Load type codes, the gaps are unknown types
    localparam logic [2:0] LOAD_BYTE   = 3'd0;
    localparam logic [2:0] LOAD_HALF   = 3'd1;
    localparam logic [2:0] LOAD_WORD   = 3'd2;
    localparam logic [2:0] LOAD_BYTE_U = 3'd4;
    localparam logic [2:0] LOAD_HALF_U = 3'd5;

    // Store type codes, 3 is unknown
    localparam logic [1:0] STORE_BYTE = 2'd0;
    localparam logic [1:0] STORE_HALF = 2'd1;
    localparam logic [1:0] STORE_WORD = 2'd2;

    // Line transfer FSM states
    localparam logic [2:0] LT_IDLE     = 3'd0;
    localparam logic [2:0] LT_WB_PRIME = 3'd1;
    localparam logic [2:0] LT_WB       = 3'd2;
    localparam logic [2:0] LT_RD_CMD   = 3'd3;
    localparam logic [2:0] LT_RD_DATA  = 3'd4;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [LANES_W-1:0]  lane;
        logic [OFFSET_W-1:0] offset;
        logic [1:0]          byte_offset;
    } cache_addr_fields_t;

    typedef union packed {
        logic [31:0]        raw;
        cache_addr_fields_t fields;
    } cache_addr_t;

endpackage

`default_nettype wire

// ==== logic/cache_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_top (
    input  logic        clk,
    input  logic        rst_n,

    input  logic [31:0] address,
    input  logic        load,
    input  logic [2:0]  load_type,
    input  logic        store,
    input  logic [1:0]  store_type,
    input  logic [31:0] store_data,
    output logic        busy,
    output logic        done,
    output logic [31:0] load_data,
    output logic        load_misaligned,
    output logic        load_unknown_type,
    output logic        store_misaligned,
    output logic        store_unknown_type,

    output logic [31:0] mem_address,
    output logic [cache_pkg::OFFSET_W:0] mem_burstcount,
    output logic        mem_read,
    output logic        mem_write,
    output logic [31:0] mem_writedata,
    input  logic        mem_waitrequest,
    input  logic [31:0] mem_readdata,
    input  logic        mem_readdatavalid
);

    // Lookup port of the line store
    logic                                            rd_en;
    logic [cache_pkg::LANES_W-1:0]                   rd_lane;
    logic [cache_pkg::OFFSET_W-1:0]                  rd_offset;
    logic [cache_pkg::WAYS-1:0][cache_pkg::TAG_W-1:0] rd_tag;
    logic [cache_pkg::WAYS-1:0][31:0]                rd_data;
    logic [cache_pkg::WAYS-1:0]                      rd_valid;
    logic [cache_pkg::WAYS-1:0]                      rd_dirty;

    // Store hit write
    logic                          wr_en;
    logic [cache_pkg::WAYS_W-1:0]  wr_way;
    logic [31:0]                   wr_data;
    logic                          set_dirty;

    // Held request towards the byte lane logic
    logic [31:0] hit_word;
    logic [31:0] merged_word;
    logic [1:0]  byte_offset;
    logic [2:0]  held_load_type;
    logic [1:0]  held_store_type;
    logic [31:0] held_store_data;
    logic        held_load;
    logic        held_store;
    logic        fault;

    // Miss hand-off
    logic                          miss_start;
    logic [31:0]                   miss_line_address;
    logic [cache_pkg::TAG_W-1:0]   victim_tag;
    logic                          victim_needs_writeback;
    logic [cache_pkg::WAYS_W-1:0]  victim_way;
    logic                          fill_done;

    // Transfer side of the line store
    logic                           fill_rd_en;
    logic [cache_pkg::OFFSET_W-1:0] fill_word;
    logic                           fill_wr_en;
    logic [cache_pkg::TAG_W-1:0]    fill_tag;
    logic [31:0]                    fill_data;
    logic [cache_pkg::WAYS_W-1:0]   fill_way;
    logic [cache_pkg::LANES_W-1:0]  fill_lane;

    access_stage u_access_stage (.*);

    byte_lanes u_byte_lanes (.*);

    line_store u_line_store (.*);

    line_transfer u_line_transfer (.*);

endmodule

`default_nettype wire

// ==== logic/line_store.sv ====
`default_nettype none
`timescale 1ns/1ps

module line_store (
    input  logic clk,
    input  logic rst_n,

    input  logic                                            rd_en,
    input  logic [cache_pkg::LANES_W-1:0]                   rd_lane,
    input  logic [cache_pkg::OFFSET_W-1:0]                  rd_offset,
    output logic [cache_pkg::WAYS-1:0][cache_pkg::TAG_W-1:0] rd_tag,
    output logic [cache_pkg::WAYS-1:0][31:0]                rd_data,
    output logic [cache_pkg::WAYS-1:0]                      rd_valid,
    output logic [cache_pkg::WAYS-1:0]                      rd_dirty,

    input  logic                         wr_en,
    input  logic [cache_pkg::WAYS_W-1:0] wr_way,
    input  logic [31:0]                  wr_data,
    input  logic                         set_dirty,

    input  logic                           fill_rd_en,
    input  logic [cache_pkg::OFFSET_W-1:0] fill_word,
    input  logic                           fill_wr_en,
    input  logic [cache_pkg::TAG_W-1:0]    fill_tag,
    input  logic [31:0]                    fill_data,
    input  logic [cache_pkg::WAYS_W-1:0]   fill_way,
    input  logic [cache_pkg::LANES_W-1:0]  fill_lane
);

    logic [31:0] data_mem [cache_pkg::WAYS][2**(cache_pkg::LANES_W+cache_pkg::OFFSET_W)];
    logic [cache_pkg::TAG_W-1:0] tag_mem [cache_pkg::WAYS][2**cache_pkg::LANES_W];
    logic [cache_pkg::WAYS-1:0]  valid_bits [2**cache_pkg::LANES_W];
    logic [cache_pkg::WAYS-1:0]  dirty_bits [2**cache_pkg::LANES_W];

    logic [cache_pkg::LANES_W-1:0]  lat_lane;
    logic [cache_pkg::OFFSET_W-1:0] lat_offset;
    logic [cache_pkg::LANES_W-1:0]  read_lane;
    logic [cache_pkg::OFFSET_W-1:0] read_offset;
    logic                           fill_last;

    // Transfer engine owns the read port while it runs
    assign read_lane   = fill_rd_en ? fill_lane : rd_lane;
    assign read_offset = fill_rd_en ? fill_word : rd_offset;
    assign fill_last   = fill_wr_en &&
                         fill_word == cache_pkg::OFFSET_W'(cache_pkg::LINE_WORDS - 1);

    always_ff @(posedge clk) begin
        if (rd_en || fill_rd_en) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                rd_data[w] <= data_mem[w][{read_lane, read_offset}];
                rd_tag[w]  <= tag_mem[w][read_lane];
            end
            rd_valid <= valid_bits[read_lane];
            rd_dirty <= dirty_bits[read_lane];
            // Bypass a store hit landing on the same edge
            if (wr_en && {read_lane, read_offset} == {lat_lane, lat_offset}) begin
                rd_data[wr_way] <= wr_data;
            end
            if (set_dirty && read_lane == lat_lane) begin
                rd_dirty[wr_way] <= 1'b1;
            end
        end
        if (rd_en) begin
            lat_lane   <= rd_lane;
            lat_offset <= rd_offset;
        end
    end

    // Store hits go to the word of the last lookup
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_way][{lat_lane, lat_offset}] <= wr_data;
        end
        if (fill_wr_en) begin
            data_mem[fill_way][{fill_lane, fill_word}] <= fill_data;
        end
        if (fill_last) begin
            tag_mem[fill_way][fill_lane] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int l = 0; l < 2**cache_pkg::LANES_W; l++) begin
                valid_bits[l] <= '0;
                dirty_bits[l] <= '0;
            end
        end else begin
            if (fill_last) begin
                valid_bits[fill_lane][fill_way] <= 1'b1;
                dirty_bits[fill_lane][fill_way] <= 1'b0;
            end
            if (set_dirty) begin
                dirty_bits[lat_lane][wr_way] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/line_transfer.sv ====
`default_nettype none
`timescale 1ns/1ps

module line_transfer (
    input  logic clk,
    input  logic rst_n,

    input  logic                         miss_start,
    input  logic [31:0]                  miss_line_address,
    input  logic [cache_pkg::TAG_W-1:0]  victim_tag,
    input  logic                         victim_needs_writeback,
    output logic                         fill_done,
    output logic [cache_pkg::WAYS_W-1:0] victim_way,

    output logic                           fill_rd_en,
    output logic [cache_pkg::OFFSET_W-1:0] fill_word,
    output logic                           fill_wr_en,
    output logic [cache_pkg::TAG_W-1:0]    fill_tag,
    output logic [31:0]                    fill_data,
    output logic [cache_pkg::WAYS_W-1:0]   fill_way,
    output logic [cache_pkg::LANES_W-1:0]  fill_lane,
    input  logic [cache_pkg::WAYS-1:0][31:0] rd_data,

    output logic [31:0]                  mem_address,
    output logic [cache_pkg::OFFSET_W:0] mem_burstcount,
    output logic                         mem_read,
    output logic                         mem_write,
    output logic [31:0]                  mem_writedata,
    input  logic                         mem_waitrequest,
    input  logic [31:0]                  mem_readdata,
    input  logic                         mem_readdatavalid
);

    logic [2:0]                     state;
    logic [cache_pkg::OFFSET_W-1:0] count;
    logic [cache_pkg::TAG_W-1:0]    vtag_q;
    cache_pkg::cache_addr_t         line_addr;
    cache_pkg::cache_addr_t         wb_addr;
    logic                           last_word;
    logic                           word_taken;

    // Victim line shares lane with the missed line
    always_comb begin
        wb_addr             = line_addr;
        wb_addr.fields.tag  = vtag_q;
    end

    assign last_word  = count == cache_pkg::OFFSET_W'(cache_pkg::LINE_WORDS - 1);
    assign word_taken = state == cache_pkg::LT_WB && !mem_waitrequest;

    // Next victim word is fetched as the current one is accepted
    assign fill_rd_en = state == cache_pkg::LT_WB_PRIME || (word_taken && !last_word);
    assign fill_word  = word_taken ? count + 1'b1 : count;
    assign fill_wr_en = state == cache_pkg::LT_RD_DATA && mem_readdatavalid;
    assign fill_done  = fill_wr_en && last_word;
    assign fill_tag   = line_addr.fields.tag;
    assign fill_lane  = line_addr.fields.lane;
    assign fill_data  = mem_readdata;
    assign fill_way   = victim_way;

    assign mem_address    = state == cache_pkg::LT_WB ? wb_addr.raw : line_addr.raw;
    assign mem_burstcount = (cache_pkg::OFFSET_W + 1)'(cache_pkg::LINE_WORDS);
    assign mem_read       = state == cache_pkg::LT_RD_CMD;
    assign mem_write      = state == cache_pkg::LT_WB;
    assign mem_writedata  = rd_data[victim_way];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= cache_pkg::LT_IDLE;
            count      <= '0;
            victim_way <= '0;
        end else begin
            case (state)
                cache_pkg::LT_IDLE: begin
                    count <= '0;
                    if (miss_start) begin
                        state <= victim_needs_writeback ? cache_pkg::LT_WB_PRIME
                                                        : cache_pkg::LT_RD_CMD;
                    end
                end
                cache_pkg::LT_WB_PRIME: state <= cache_pkg::LT_WB;
                cache_pkg::LT_WB: begin
                    if (word_taken) begin
                        count <= count + 1'b1;
                        if (last_word) begin
                            state <= cache_pkg::LT_RD_CMD;
                        end
                    end
                end
                cache_pkg::LT_RD_CMD: begin
                    if (!mem_waitrequest) begin
                        state <= cache_pkg::LT_RD_DATA;
                    end
                end
                cache_pkg::LT_RD_DATA: begin
                    if (fill_wr_en) begin
                        count <= count + 1'b1;
                        if (last_word) begin
                            state      <= cache_pkg::LT_IDLE;
                            victim_way <= victim_way + 1'b1;
                        end
                    end
                end
                default: state <= cache_pkg::LT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::LT_IDLE && miss_start) begin
            line_addr <= miss_line_address;
            vtag_q    <= victim_tag;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_cache -f compile.f -o tb_cache_sim > build.log 2>&1 &&
    ./obj_dir/tb_cache_sim > sim.log 2>&1 ||
    { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0

// ==== testbench/cache_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_asserts (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         busy,
    input  logic                         done,
    input  logic [31:0]                  mem_address,
    input  logic [cache_pkg::OFFSET_W:0] mem_burstcount,
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic [31:0]                  mem_writedata,
    input  logic                         mem_waitrequest
);

    // Only one kind of burst on the bus at a time
    a_no_read_write_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high in the same cycle");

    // Stalled command must not move
    a_command_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) && mem_waitrequest |=>
            $stable(mem_read) && $stable(mem_write) && $stable(mem_address) &&
            $stable(mem_writedata) && $stable(mem_burstcount))
        else $error("memory command changed while waitrequest was high");

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && busy))
        else $error("done and busy are high in the same cycle");

endmodule

`default_nettype wire

// ==== testbench/cache_golden.txt ====
# op type address store_data load_data flags hit (all hex)
# flags: 8 load misaligned, 4 load unknown, 2 store misaligned, 1 store unknown
L 2 00001000 00000000 c0de1000 0 0
L 2 00001004 00000000 c0de1004 0 1
L 0 00001008 00000000 00000008 0 1
L 0 00001009 00000000 00000010 0 1
L 0 0000100a 00000000 ffffffde 0 1
L 0 0000100b 00000000 ffffffc0 0 1
L 4 0000100a 00000000 000000de 0 1
L 4 0000100b 00000000 000000c0 0 1
L 1 00001008 00000000 00001008 0 1
L 1 0000100a 00000000 ffffc0de 0 1
L 5 0000100a 00000000 0000c0de 0 1
S 0 00001011 000000ab 00000000 0 1
L 2 00001010 00000000 c0deab10 0 1
S 1 00001016 00001234 00000000 0 1
L 2 00001014 00000000 12341014 0 1
S 2 00001018 deadbeef 00000000 0 1
L 2 00001018 00000000 deadbeef 0 1
S 2 00002000 11111111 00000000 0 0
S 2 00003000 22222222 00000000 0 0
S 2 00004000 33333333 00000000 0 0
L 2 00002000 00000000 11111111 0 0
L 2 00003000 00000000 22222222 0 0
L 2 00004000 00000000 33333333 0 0
L 2 00001010 00000000 c0deab10 0 0
L 2 00001018 00000000 deadbeef 0 1
L 2 00001012 00000000 00000000 8 1
L 1 00001011 00000000 00000000 8 1
L 3 00001010 00000000 00000000 4 1
S 2 00001012 ffffffff 00000000 2 1
S 1 00001013 0000ffff 00000000 2 1
S 3 00001010 ffffffff 00000000 1 1
L 2 00001010 00000000 c0deab10 0 1
L 2 00001014 00000000 12341014 0 1
S 2 00005002 ffffffff 00000000 2 1
L 2 00005000 00000000 c0de5000 0 0

// ==== testbench/tb_cache.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_cache;

    localparam int DONE_TIMEOUT = 2000;

    logic        clk;
    logic        rst_n;
    logic [31:0] address;
    logic        load;
    logic [2:0]  load_type;
    logic        store;
    logic [1:0]  store_type;
    logic [31:0] store_data;
    logic        busy;
    logic        done;
    logic [31:0] load_data;
    logic        load_misaligned;
    logic        load_unknown_type;
    logic        store_misaligned;
    logic        store_unknown_type;
    logic [31:0] mem_address;
    logic [cache_pkg::OFFSET_W:0] mem_burstcount;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] mem_writedata;
    logic        mem_waitrequest;
    logic [31:0] mem_readdata;
    logic        mem_readdatavalid;

    // Memory model keeps only the words that were written
    logic [31:0] mem_words [logic [31:0]];
    logic [31:0] rd_base;
    int          rd_left;
    int          rd_index;
    int          wr_index;
    int          write_bursts;

    int checks;
    int errors;
    int timeouts;

    cache_top u_cache_top (.*);

    bind cache_top cache_asserts u_cache_asserts (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] mem_word_at(input logic [31:0] byte_address);
        if (mem_words.exists(byte_address)) begin
            return mem_words[byte_address];
        end
        // Untouched words hold their own address with a marker
        return byte_address ^ 32'hC0DE_0000;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Burst memory with random stalls and gaps in the read data
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_left  = 0;
            rd_index = 0;
            wr_index = 0;
            mem_waitrequest   <= 1'b0;
            mem_readdatavalid <= 1'b0;
        end else begin
            // Word offered before this edge was taken
            if (mem_readdatavalid) begin
                rd_index = rd_index + 1;
                rd_left  = rd_left - 1;
            end
            if (mem_write && !mem_waitrequest) begin
                if (wr_index == 0) begin
                    write_bursts = write_bursts + 1;
                    check_value("write burst length", cache_pkg::LINE_WORDS,
                                32'(mem_burstcount));
                    check_value("write burst alignment", 0, 32'(mem_address[5:0]));
                end
                mem_words[mem_address + 32'(4 * wr_index)] = mem_writedata;
                wr_index = (wr_index + 1) % cache_pkg::LINE_WORDS;
            end
            if (mem_read && !mem_waitrequest) begin
                check_value("read burst length", cache_pkg::LINE_WORDS, 32'(mem_burstcount));
                check_value("read burst alignment", 0, 32'(mem_address[5:0]));
                rd_base  = mem_address;
                rd_left  = cache_pkg::LINE_WORDS;
                rd_index = 0;
            end
            mem_waitrequest <= ($urandom % 3) == 0;
            if (rd_left > 0 && ($urandom % 4) != 0) begin
                mem_readdatavalid <= 1'b1;
                mem_readdata      <= mem_word_at(rd_base + 32'(4 * rd_index));
            end else begin
                mem_readdatavalid <= 1'b0;
            end
        end
    end

    task automatic run_access(input int line_no, input logic [7:0] op,
                              input logic [31:0] kind, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] exp_data,
                              input logic [31:0] exp_flags, input logic [31:0] exp_hit,
                              output bit timed_out);
        int    cycles;
        bit    seen;
        string test_name;
        test_name = $sformatf("golden line %0d", line_no);
        @(posedge clk);
        address    <= addr;
        load       <= op == "L";
        store      <= op == "S";
        load_type  <= (op == "L") ? kind[2:0] : 3'd0;
        store_type <= (op == "S") ? kind[1:0] : 2'd0;
        store_data <= data;
        // Accepting edge
        @(posedge clk);
        load  <= 1'b0;
        store <= 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = done;
            // A miss holds busy high up to the cycle of done
            if (!seen) begin
                check_value({test_name, " busy before done"}, 1, 32'(busy));
            end
        end
        timed_out = !seen;
        if (!seen) begin
            $display("Timeout: done never arrived for %s", test_name);
        end else begin
            check_value({test_name, " flags"}, exp_flags,
                        {28'd0, load_misaligned, load_unknown_type,
                         store_misaligned, store_unknown_type});
            if (op == "L" && exp_flags == 0) begin
                check_value({test_name, " load data"}, exp_data, load_data);
            end
            if (exp_hit != 0) begin
                check_value({test_name, " cycles to done"}, 1, 32'(cycles));
            end else begin
                check_value({test_name, " took the miss path"}, 1, 32'(cycles > 1));
            end
        end
    endtask

    initial begin
        int               fd;
        int               line_no;
        int               fields;
        bit               timed_out;
        logic [8*128-1:0] line_buf;
        logic [7:0]       op;
        logic [31:0]      kind;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      exp_data;
        logic [31:0]      exp_flags;
        logic [31:0]      exp_hit;

        clk               = 1'b0;
        rst_n             = 1'b0;
        address           = '0;
        load              = 1'b0;
        load_type         = '0;
        store             = 1'b0;
        store_type        = '0;
        store_data        = '0;
        mem_waitrequest   = 1'b0;
        mem_readdata      = '0;
        mem_readdatavalid = 1'b0;
        write_bursts      = 0;
        checks            = 0;
        errors            = 0;
        timeouts          = 0;
        timed_out         = 1'b0;
        void'($urandom(32'h5738_0dea));

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("testbench/cache_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open testbench/cache_golden.txt");
        end else begin
            line_no = 0;
            while (!timed_out && $fgets(line_buf, fd) != 0) begin
                line_no++;
                fields = $sscanf(line_buf, "%s %h %h %h %h %h %h", op, kind, addr, data,
                                 exp_data, exp_flags, exp_hit);
                if (fields >= 1 && op != "#") begin
                    if (fields != 7) begin
                        errors++;
                        $display("Golden line %0d has %0d fields instead of 7",
                                 line_no, fields);
                    end else begin
                        run_access(line_no, op, kind, addr, data, exp_data, exp_flags,
                                   exp_hit, timed_out);
                        if (timed_out) begin
                            timeouts++;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        // Dirty evictions must have reached memory
        if (write_bursts == 0) begin
            errors++;
            $display("No write burst was seen, dirty lines were never written back");
        end

        $display("Checks: %0d  errors: %0d  timeouts: %0d  write bursts: %0d",
                 checks, errors, timeouts, write_bursts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
